/* hw/hazard_pkg.sv */
// hazard detector shared types
package hazard_pkg;

  // architectural register address
  localparam int reg_addr_width_lp = 5;
  typedef logic [reg_addr_width_lp-1:0] reg_addr_t;

  // tracked stages after dispatch, the stage rules in hazard_check assume 4
  localparam int dep_depth_lp = 4;

  // execution pipe of a dispatched instruction
  typedef enum logic [2:0] {
    PIPE_CTL,
    PIPE_INT,
    PIPE_AUX,
    PIPE_MEM_EARLY,
    PIPE_MEM_FINAL,
    PIPE_MUL,
    PIPE_LONG
  } pipe_e;

  // instruction waiting in issue
  typedef struct packed {
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      irs1_v;
    logic      irs2_v;
    logic      iwb_v;
    logic      fence_v;
    logic      mem_v;
    logic      csr_v;
    logic      long_v;
  } isd_status_s;

  // instruction leaving issue this cycle
  typedef struct packed {
    logic      v;
    pipe_e     pipe;
    logic      irf_w_v;
    logic      mem_v;
    logic      csr_v;
    logic      late_iwb_v;
    reg_addr_t rd_addr;
  } dispatch_pkt_s;

  // one stage of the dependency pipe
  typedef struct packed {
    logic      instr_v;
    logic      mem_v;
    logic      csr_v;
    logic      aux_iwb_v;
    logic      mul_iwb_v;
    logic      emem_iwb_v;
    logic      fmem_iwb_v;
    reg_addr_t rd_addr;
  } dep_status_s;

  // integer writeback
  typedef struct packed {
    logic      ird_w_v;
    logic      late;
    reg_addr_t rd_addr;
  } wb_pkt_s;

  // levels from the execution units and the front of the core
  typedef struct packed {
    logic mem_ready;
    logic idiv_ready;
    logic ptw_busy;
    logic cmd_full;
    logic credits_full;
    logic credits_empty;
    logic irq_pending;
  } unit_status_s;

endpackage

/* hw/dep_pipe.sv */
// dependency status pipeline
module dep_pipe
  import hazard_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  dispatch_pkt_s                    dispatch_pkt_i,
  output dep_status_s [dep_depth_lp-1:0]   dep_status_o
);

  dep_status_s                   dep_status_n;
  dep_status_s [dep_depth_lp-1:0] dep_status_r;

  // writeback class comes from the pipe, only when the instruction writes the int rf
  always_comb
  begin
    dep_status_n            = '0;
    dep_status_n.instr_v    = 1'b1;
    dep_status_n.mem_v      = dispatch_pkt_i.mem_v;
    dep_status_n.csr_v      = dispatch_pkt_i.csr_v;
    dep_status_n.aux_iwb_v  = (dispatch_pkt_i.pipe == PIPE_AUX) & dispatch_pkt_i.irf_w_v;
    dep_status_n.mul_iwb_v  = (dispatch_pkt_i.pipe == PIPE_MUL) & dispatch_pkt_i.irf_w_v;
    dep_status_n.emem_iwb_v = (dispatch_pkt_i.pipe == PIPE_MEM_EARLY)
                              & dispatch_pkt_i.irf_w_v;
    dep_status_n.fmem_iwb_v = (dispatch_pkt_i.pipe == PIPE_MEM_FINAL)
                              & dispatch_pkt_i.irf_w_v;
    dep_status_n.rd_addr    = dispatch_pkt_i.rd_addr;
  end

  // bubble enters as all zero, oldest entry drops off the end
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dep_status_r <= '0;
    end
    else
    begin
      dep_status_r[0]                <= dispatch_pkt_i.v ? dep_status_n : '0;
      dep_status_r[dep_depth_lp-1:1] <= dep_status_r[dep_depth_lp-2:0];
    end
  end

  assign dep_status_o = dep_status_r;

  // an empty stage 0 must not carry stale class flags into the hazard rules
  idle_stage_clean_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !dep_status_r[0].instr_v |-> !(dep_status_r[0].mem_v
                                   | dep_status_r[0].csr_v
                                   | dep_status_r[0].aux_iwb_v
                                   | dep_status_r[0].mul_iwb_v
                                   | dep_status_r[0].emem_iwb_v
                                   | dep_status_r[0].fmem_iwb_v)
  );

endmodule

/* hw/int_scoreboard.sv */
// integer late writeback scoreboard
module int_scoreboard
  import hazard_pkg::*;
#(
  parameter int num_regs_p = 32
)
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  dispatch_pkt_s dispatch_pkt_i,
  input  wb_pkt_s       iwb_pkt_i,
  input  reg_addr_t     rs1_addr_i,
  input  reg_addr_t     rs2_addr_i,
  input  reg_addr_t     rd_addr_i,
  output logic [1:0]    rs_match_o,
  output logic          rd_match_o
);

  localparam int idx_width_lp = $clog2(num_regs_p);

  logic [num_regs_p-1:0]   pending_r;
  logic [num_regs_p-1:0]   pending_n;
  logic                    score_v;
  logic                    clear_v;
  logic [idx_width_lp-1:0] score_idx;
  logic [idx_width_lp-1:0] clear_idx;

  // x0 is never scored since it has no real writeback
  assign score_v   = dispatch_pkt_i.v & dispatch_pkt_i.late_iwb_v
                     & (dispatch_pkt_i.rd_addr != '0);
  assign clear_v   = iwb_pkt_i.ird_w_v & iwb_pkt_i.late;
  assign score_idx = dispatch_pkt_i.rd_addr[idx_width_lp-1:0];
  assign clear_idx = iwb_pkt_i.rd_addr[idx_width_lp-1:0];

  // score applied last so it wins over a same-cycle clear
  always_comb
  begin
    pending_n = pending_r;
    if (clear_v)
      pending_n[clear_idx] = 1'b0;
    if (score_v)
      pending_n[score_idx] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pending_r <= '0;
    else
      pending_r <= pending_n;
  end

  // lookups see only registered state
  assign rs_match_o[0] = pending_r[rs1_addr_i[idx_width_lp-1:0]];
  assign rs_match_o[1] = pending_r[rs2_addr_i[idx_width_lp-1:0]];
  assign rd_match_o    = pending_r[rd_addr_i[idx_width_lp-1:0]];

  // every late writeback pairs with an earlier scored dispatch
  clear_was_pending_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    clear_v |-> pending_r[clear_idx]
  );

  x0_never_pending_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !pending_r[0]
  );

endmodule

/* hw/hazard_check.sv */
// dispatch hazard evaluation
module hazard_check
  import hazard_pkg::*;
(
  input  isd_status_s                    isd_status_i,
  input  dep_status_s [dep_depth_lp-1:0] dep_status_i,
  input  logic [1:0]                     rs_match_i,
  input  logic                           rd_match_i,
  input  unit_status_s                   unit_status_i,
  output logic                           dispatch_v_o,
  output logic                           interrupt_v_o
);

  // stages 0 to 2 are still ahead of commit for ordering purposes
  localparam int order_stages_lp = 3;

  reg_addr_t [1:0] rs_addr;
  logic [1:0]      rs_active;
  logic [1:0]      stage0_haz;
  logic [1:0]      stage1_haz;
  logic [1:0]      sb_raw_haz;
  logic            sb_waw_haz;
  logic            stage0_late;
  logic            stage1_late;
  logic            mem_in_pipe;
  logic            instr_in_pipe;
  logic            fence_haz;
  logic            csr_haz;
  logic            long_haz;
  logic            data_haz;
  logic            control_haz;
  logic            struct_haz;

  assign rs_addr[0] = isd_status_i.rs1_addr;
  assign rs_addr[1] = isd_status_i.rs2_addr;

  // x0 reads never depend on anything
  assign rs_active[0] = isd_status_i.irs1_v & (isd_status_i.rs1_addr != '0);
  assign rs_active[1] = isd_status_i.irs2_v & (isd_status_i.rs2_addr != '0);

  // results not yet forwardable out of stage 0 and stage 1
  assign stage0_late = dep_status_i[0].aux_iwb_v
                       | dep_status_i[0].mul_iwb_v
                       | dep_status_i[0].emem_iwb_v
                       | dep_status_i[0].fmem_iwb_v;
  assign stage1_late = dep_status_i[1].fmem_iwb_v | dep_status_i[1].mul_iwb_v;

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      stage0_haz[i] = rs_active[i] & stage0_late
                      & (rs_addr[i] == dep_status_i[0].rd_addr);
      stage1_haz[i] = rs_active[i] & stage1_late
                      & (rs_addr[i] == dep_status_i[1].rd_addr);
      sb_raw_haz[i] = rs_active[i] & rs_match_i[i];
    end
  end

  assign sb_waw_haz = isd_status_i.iwb_v & (isd_status_i.rd_addr != '0) & rd_match_i;

  always_comb
  begin
    mem_in_pipe   = 1'b0;
    instr_in_pipe = 1'b0;
    for (int s = 0; s < order_stages_lp; s++)
    begin
      mem_in_pipe   = mem_in_pipe | dep_status_i[s].mem_v;
      instr_in_pipe = instr_in_pipe | dep_status_i[s].instr_v;
    end
  end

  // a fence waits for all memory traffic to drain
  assign fence_haz = (isd_status_i.fence_v
                      & (~unit_status_i.credits_empty | mem_in_pipe | ~unit_status_i.mem_ready))
                     | (isd_status_i.mem_v & unit_status_i.credits_full);

  // csr and long ops run alone, pessimistic but simple
  assign csr_haz  = isd_status_i.csr_v & instr_in_pipe;
  assign long_haz = isd_status_i.long_v & instr_in_pipe;

  assign data_haz = (|stage0_haz) | (|stage1_haz) | (|sb_raw_haz) | sb_waw_haz;

  assign control_haz = fence_haz | csr_haz | long_haz;

  assign struct_haz = unit_status_i.ptw_busy
                      | unit_status_i.cmd_full
                      | (isd_status_i.mem_v & ~unit_status_i.mem_ready)
                      | (isd_status_i.long_v & ~unit_status_i.idiv_ready);

  always_comb
  begin
    dispatch_v_o = ~(data_haz | control_haz | struct_haz);
    // the walker owns the pipe, nothing may issue behind it
    assert (!(unit_status_i.ptw_busy && dispatch_v_o))
      else $error("dispatch granted during page table walk");
  end

  // interrupt is held off while a walk is in flight
  assign interrupt_v_o = unit_status_i.irq_pending & ~unit_status_i.ptw_busy;

endmodule

/* hw/hazard_detector.sv */
// dispatch hazard detector
module hazard_detector
  import hazard_pkg::*;
#(
  parameter int num_regs_p = 32
)
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  isd_status_s   isd_status_i,
  input  dispatch_pkt_s dispatch_pkt_i,
  input  wb_pkt_s       iwb_pkt_i,
  input  unit_status_s  unit_status_i,
  output logic          dispatch_v_o,
  output logic          interrupt_v_o
);

  dep_status_s [dep_depth_lp-1:0] dep_status;
  logic [1:0]                     rs_match;
  logic                           rd_match;

  // status of in-flight instructions
  dep_pipe u_dep_pipe (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .dep_status_o   (dep_status)
  );

  // long latency integer results
  int_scoreboard #(
    .num_regs_p (num_regs_p)
  ) u_int_scoreboard (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .iwb_pkt_i      (iwb_pkt_i),
    .rs1_addr_i     (isd_status_i.rs1_addr),
    .rs2_addr_i     (isd_status_i.rs2_addr),
    .rd_addr_i      (isd_status_i.rd_addr),
    .rs_match_o     (rs_match),
    .rd_match_o     (rd_match)
  );

  hazard_check u_hazard_check (
    .isd_status_i  (isd_status_i),
    .dep_status_i  (dep_status),
    .rs_match_i    (rs_match),
    .rd_match_i    (rd_match),
    .unit_status_i (unit_status_i),
    .dispatch_v_o  (dispatch_v_o),
    .interrupt_v_o (interrupt_v_o)
  );

endmodule

/* include/tb_hazard_model.svh */
// hazard detector reference model
`ifndef TB_HAZARD_MODEL_SVH
`define TB_HAZARD_MODEL_SVH

localparam int model_regs_lp = 32;

dep_status_s [dep_depth_lp-1:0] model_dep_q;
logic [model_regs_lp-1:0]       model_pending;

function automatic void model_reset();
  model_dep_q   = '0;
  model_pending = '0;
endfunction

// expected dispatch_v_o for the current model state
function automatic logic model_dispatch(isd_status_s isd, unit_status_s us);
  reg_addr_t src[2];
  logic      src_v[2];
  logic      haz;
  logic      mem_busy;
  logic      any_busy;
  src[0]   = isd.rs1_addr;
  src[1]   = isd.rs2_addr;
  src_v[0] = isd.irs1_v && (isd.rs1_addr != '0);
  src_v[1] = isd.irs2_v && (isd.rs2_addr != '0);
  haz      = us.ptw_busy || us.cmd_full;
  mem_busy = model_dep_q[0].mem_v || model_dep_q[1].mem_v || model_dep_q[2].mem_v;
  any_busy = model_dep_q[0].instr_v || model_dep_q[1].instr_v || model_dep_q[2].instr_v;
  for (int i = 0; i < 2; i++)
  begin
    if (src_v[i] && model_pending[src[i]])
      haz = 1'b1;
    if (src_v[i] && (src[i] == model_dep_q[0].rd_addr)
        && (model_dep_q[0].aux_iwb_v || model_dep_q[0].mul_iwb_v
            || model_dep_q[0].emem_iwb_v || model_dep_q[0].fmem_iwb_v))
      haz = 1'b1;
    if (src_v[i] && (src[i] == model_dep_q[1].rd_addr)
        && (model_dep_q[1].mul_iwb_v || model_dep_q[1].fmem_iwb_v))
      haz = 1'b1;
  end
  if (isd.iwb_v && (isd.rd_addr != '0) && model_pending[isd.rd_addr])
    haz = 1'b1;
  if (isd.fence_v && (!us.credits_empty || mem_busy || !us.mem_ready))
    haz = 1'b1;
  if (isd.mem_v && (us.credits_full || !us.mem_ready))
    haz = 1'b1;
  if ((isd.csr_v || isd.long_v) && any_busy)
    haz = 1'b1;
  if (isd.long_v && !us.idiv_ready)
    haz = 1'b1;
  return !haz;
endfunction

function automatic logic model_interrupt(unit_status_s us);
  return us.irq_pending && !us.ptw_busy;
endfunction

// advance the model by one clock edge
function automatic void model_step(dispatch_pkt_s pkt, wb_pkt_s wb);
  dep_status_s e;
  e = '0;
  if (pkt.v)
  begin
    e.instr_v    = 1'b1;
    e.mem_v      = pkt.mem_v;
    e.csr_v      = pkt.csr_v;
    e.aux_iwb_v  = pkt.irf_w_v && (pkt.pipe == PIPE_AUX);
    e.mul_iwb_v  = pkt.irf_w_v && (pkt.pipe == PIPE_MUL);
    e.emem_iwb_v = pkt.irf_w_v && (pkt.pipe == PIPE_MEM_EARLY);
    e.fmem_iwb_v = pkt.irf_w_v && (pkt.pipe == PIPE_MEM_FINAL);
    e.rd_addr    = pkt.rd_addr;
  end
  model_dep_q = {model_dep_q[dep_depth_lp-2:0], e};
  if (wb.ird_w_v && wb.late)
    model_pending[wb.rd_addr] = 1'b0;
  if (pkt.v && pkt.late_iwb_v && (pkt.rd_addr != '0))
    model_pending[pkt.rd_addr] = 1'b1;
endfunction

`endif

/* tests/tb_hazard_detector.sv */
// hazard detector testbench
module tb_hazard_detector
  import hazard_pkg::*;
();

  localparam int directed_cycles_lp = 7;
  localparam int random_cycles_lp   = 2000 - directed_cycles_lp;
  // 2 reset cycles plus 2000 test cycles, with some margin
  localparam int timeout_cycles_lp  = 2100;

  logic          clk_i;
  logic          rst_n_i;
  isd_status_s   isd_status;
  dispatch_pkt_s dispatch_pkt;
  wb_pkt_s       iwb_pkt;
  unit_status_s  unit_status;
  logic          dispatch_v;
  logic          interrupt_v;

  // inputs for the coming cycle
  isd_status_s   nx_isd;
  dispatch_pkt_s nx_pkt;
  wb_pkt_s       nx_wb;
  unit_status_s  nx_us;

  logic [31:0] rng_state;
  int          cycle_cnt;

  `include "tb_hazard_model.svh"

  hazard_detector #(
    .num_regs_p (32)
  ) u_dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .isd_status_i   (isd_status),
    .dispatch_pkt_i (dispatch_pkt),
    .iwb_pkt_i      (iwb_pkt),
    .unit_status_i  (unit_status),
    .dispatch_v_o   (dispatch_v),
    .interrupt_v_o  (interrupt_v)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles_lp)
    begin
      $display("the test did not finish within %0d cycles", timeout_cycles_lp);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_dispatch(logic actual, logic expected, string what);
    if (actual !== expected)
    begin
      $display("FAILED %0t: dispatch_v_o is %b, expected %b (%s)", $time, actual, expected, what);
      $display("SOME TESTS FAILED");
      $fatal(1, "dispatch mismatch");
    end
  endtask

  task automatic check_interrupt(logic actual, logic expected, string what);
    if (actual !== expected)
    begin
      $display("FAILED %0t: interrupt_v_o is %b, expected %b (%s)", $time, actual, expected, what);
      $display("SOME TESTS FAILED");
      $fatal(1, "interrupt mismatch");
    end
  endtask

  // nothing issued, nothing dispatched, units idle and ready
  task automatic set_idle_next();
    nx_isd              = '0;
    nx_pkt              = '0;
    nx_wb               = '0;
    nx_us               = '0;
    nx_us.mem_ready     = 1'b1;
    nx_us.idiv_ready    = 1'b1;
    nx_us.credits_empty = 1'b1;
  endtask

  // called at a rising edge, exp_disp below 0 means the model alone decides
  task automatic run_cycle(int exp_disp, string what);
    isd_status   <= nx_isd;
    dispatch_pkt <= nx_pkt;
    iwb_pkt      <= nx_wb;
    unit_status  <= nx_us;
    @(negedge clk_i);
    check_dispatch(dispatch_v, model_dispatch(isd_status, unit_status), what);
    check_interrupt(interrupt_v, model_interrupt(unit_status), what);
    if (exp_disp >= 0)
      check_dispatch(dispatch_v, exp_disp == 1, what);
    @(posedge clk_i);
    model_step(dispatch_pkt, iwb_pkt);
    set_idle_next();
  endtask

  // register pool 0 to 3, unit levels mostly benign
  task automatic random_next();
    logic [31:0] r;
    logic [1:0]  clr_reg;
    r = next_rand();
    nx_isd.rs1_addr = reg_addr_t'(r[1:0]);
    nx_isd.rs2_addr = reg_addr_t'(r[3:2]);
    nx_isd.rd_addr  = reg_addr_t'(r[5:4]);
    nx_isd.irs1_v   = |r[7:6];
    nx_isd.irs2_v   = |r[9:8];
    nx_isd.iwb_v    = r[10];
    nx_isd.fence_v  = &r[14:11];
    nx_isd.mem_v    = &r[16:15];
    nx_isd.csr_v    = &r[19:17];
    nx_isd.long_v   = &r[22:20];
    r = next_rand();
    nx_pkt.v          = r[0];
    nx_pkt.pipe       = pipe_e'(r[4:1] % 7);
    nx_pkt.irf_w_v    = |r[6:5];
    nx_pkt.mem_v      = &r[8:7];
    nx_pkt.csr_v      = &r[11:9];
    nx_pkt.late_iwb_v = &r[13:12];
    nx_pkt.rd_addr    = reg_addr_t'(r[15:14]);
    // a late writeback only ever returns for a register still pending
    clr_reg       = r[17:16];
    nx_wb.rd_addr = reg_addr_t'(clr_reg);
    nx_wb.ird_w_v = r[18];
    nx_wb.late    = r[19] & model_pending[clr_reg];
    r = next_rand();
    nx_us.mem_ready     = |r[2:0];
    nx_us.idiv_ready    = |r[5:3];
    nx_us.ptw_busy      = &r[9:6];
    nx_us.cmd_full      = &r[13:10];
    nx_us.credits_full  = &r[16:14];
    nx_us.credits_empty = |r[18:17];
    nx_us.irq_pending   = &r[20:19];
  endtask

  initial
  begin
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    cycle_cnt = 0;
    rng_state = 32'd67;
    set_idle_next();
    isd_status   = nx_isd;
    dispatch_pkt = nx_pkt;
    iwb_pkt      = nx_wb;
    unit_status  = nx_us;
    model_reset();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    nx_us.irq_pending = 1'b1;
    run_cycle(1, "idle after reset");
    // multiply to x2, then readers of x2 while multiplies to x0 follow
    nx_pkt.v       = 1'b1;
    nx_pkt.pipe    = PIPE_MUL;
    nx_pkt.irf_w_v = 1'b1;
    nx_pkt.rd_addr = reg_addr_t'(2);
    run_cycle(1, "mul dispatch");
    for (int i = 0; i < 3; i++)
    begin
      nx_isd.rs1_addr = reg_addr_t'(2);
      nx_isd.irs1_v   = 1'b1;
      nx_pkt.v        = 1'b1;
      nx_pkt.pipe     = PIPE_MUL;
      nx_pkt.irf_w_v  = 1'b1;
      run_cycle((i == 2) ? 1 : 0, "reader behind mul");
    end
    nx_isd.irs1_v = 1'b1;
    nx_isd.irs2_v = 1'b1;
    run_cycle(1, "reader of x0");
    nx_us.ptw_busy    = 1'b1;
    nx_us.irq_pending = 1'b1;
    run_cycle(0, "page table walk");

    for (int n = 0; n < random_cycles_lp; n++)
    begin
      random_next();
      run_cycle(-1, "random cycle");
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
hw/hazard_pkg.sv
hw/dep_pipe.sv
hw/int_scoreboard.sv
hw/hazard_check.sv
hw/hazard_detector.sv
tests/tb_hazard_detector.sv

/* Bender.yml */
package:
  name: hazard_detector

sources:
  # package first, then the units, then the top level
  - files:
      - hw/hazard_pkg.sv
      - hw/dep_pipe.sv
      - hw/int_scoreboard.sv
      - hw/hazard_check.sv
      - hw/hazard_detector.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_hazard_detector.sv
